/* hdl/rv32_mem_pkg.sv */
package rv32_mem_pkg;

    typedef logic [31:0] rv32_word;
    typedef logic [31:0] rv32_addr;

    // Memory size in 32-bit words
    localparam int unsigned MEM_WORDS = 1024;
    localparam int unsigned WORD_ADDR_BITS = $clog2(MEM_WORDS);

    // Data port operations
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_t;

    // One word seen as byte lanes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } lane_word_u;

    function automatic logic is_load(mem_op_t op);
        logic result;
        case (op)
            MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU: result = 1'b1;
            default: result = 1'b0;
        endcase
        return result;
    endfunction

    function automatic logic is_store(mem_op_t op);
        logic result;
        case (op)
            MEM_SB, MEM_SH, MEM_SW: result = 1'b1;
            default: result = 1'b0;
        endcase
        return result;
    endfunction

endpackage

/* hdl/mem_write_if.sv */
`timescale 1ns/1ps

interface mem_write_if
    import rv32_mem_pkg::*;
(
    input logic clk
);
    logic [WORD_ADDR_BITS-1:0] word_addr;
    logic [3:0]                lane_we;
    logic [3:0][7:0]           lane_data; // Lane n goes to bank n
    logic [1:0]                byte_off;
    mem_op_t                   op;
    logic                      in_range;
    logic                      misaligned;

    // Decoder also sees clk for its checks
    modport decoder (
        input  clk,
        output word_addr, lane_we, lane_data, byte_off, op, in_range, misaligned
    );

    modport memory (
        input word_addr, lane_we, lane_data, in_range
    );

    modport result (
        input op, byte_off, misaligned
    );

endinterface

/* hdl/bram_bank.sv */
`timescale 1ns/1ps

module bram_bank
    import rv32_mem_pkg::*;
(
    input  logic                      clk,
    input  logic [WORD_ADDR_BITS-1:0] addr_a,
    input  logic [WORD_ADDR_BITS-1:0] addr_b,
    input  logic                      read_a,
    input  logic                      we_b,
    input  logic [7:0]                data_in_b,
    output logic [7:0]                data_a,
    output logic [7:0]                data_b
);
    logic [7:0] mem [MEM_WORDS];

    // Port A, fetch side, holds output when idle
    always_ff @(posedge clk) begin
        if (read_a) begin
            data_a <= mem[addr_a];
        end
    end

    // Port B always reads, old contents win on a write
    always_ff @(posedge clk) begin
        if (we_b) begin
            mem[addr_b] <= data_in_b;
        end
        data_b <= mem[addr_b];
    end

endmodule

/* hdl/mem_request_decode.sv */
`timescale 1ns/1ps

module mem_request_decode
    import rv32_mem_pkg::*;
(
    input  mem_op_t      data_op,
    input  rv32_addr     data_addr,
    input  rv32_word     data_wdata,
    mem_write_if.decoder wr
);
    lane_word_u lanes;
    logic [1:0] off;
    logic [3:0] lane_we;
    logic       in_range;
    logic       misaligned;
    logic       store_ok;

    assign off      = data_addr[1:0];
    assign in_range = data_addr[31:2] < MEM_WORDS;

    always_comb begin
        case (data_op)
            MEM_LH, MEM_LHU, MEM_SH: misaligned = off[0];
            MEM_LW, MEM_SW:          misaligned = off != 2'b00;
            default:                 misaligned = 1'b0; // Bytes never misalign
        endcase
    end

    assign store_ok = is_store(data_op) && in_range && !misaligned;

    // Replicate narrow store data so every lane carries it
    always_comb begin
        case (data_op)
            MEM_SB:  lanes.bytes  = {4{data_wdata[7:0]}};
            MEM_SH:  lanes.halves = {2{data_wdata[15:0]}};
            default: lanes        = data_wdata;
        endcase
    end

    always_comb begin
        lane_we = 4'b0000;
        if (store_ok) begin
            case (data_op)
                MEM_SB:  lane_we = 4'b0001 << off;
                MEM_SH:  lane_we = off[1] ? 4'b1100 : 4'b0011;
                MEM_SW:  lane_we = 4'b1111;
                default: lane_we = 4'b0000;
            endcase
        end
    end

    assign wr.word_addr  = data_addr[WORD_ADDR_BITS+1:2]; // Upper bits only feed in_range
    assign wr.lane_we    = lane_we;
    assign wr.lane_data  = lanes.bytes;
    assign wr.byte_off   = off;
    assign wr.op         = data_op;
    assign wr.in_range   = in_range;
    assign wr.misaligned = misaligned;

    // Loads and idle cycles must never reach the banks
    a_no_write_unless_store: assert property (
        @(posedge wr.clk) !is_store(wr.op) |-> wr.lane_we == 4'b0000
    ) else $error("lane_we set for non-store op %s", wr.op.name());

endmodule

/* hdl/rv32_main_memory.sv */
`timescale 1ns/1ps

module rv32_main_memory
    import rv32_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Instruction port
    input  rv32_addr    instr_addr,
    input  logic        instr_read,
    output logic        instr_ready,
    output rv32_word    instr,
    // Data port
    mem_write_if.memory wr,
    output logic        data_ready,
    output rv32_word    data_rdata
);
    logic [WORD_ADDR_BITS-1:0] fetch_addr;
    rv32_word                  instr_raw;
    logic                      instr_valid;

    assign fetch_addr = instr_addr[WORD_ADDR_BITS+1:2];

    // One bank per byte lane
    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        bram_bank u_bank (
            .clk       (clk),
            .addr_a    (fetch_addr),
            .addr_b    (wr.word_addr),
            .read_a    (instr_read),
            .we_b      (wr.lane_we[lane]),
            .data_in_b (wr.lane_data[lane]),
            .data_a    (instr_raw[8*lane +: 8]),
            .data_b    (data_rdata[8*lane +: 8])
        );
    end

    // Bank outputs are unknown until the first fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            instr_valid <= 1'b0;
        end else if (instr_read) begin
            instr_valid <= 1'b1;
        end
    end

    assign instr = instr_valid ? instr_raw : '0;

    assign instr_ready = instr_addr[31:2] < MEM_WORDS;
    assign data_ready  = wr.in_range; // Same check done in decode

    // Out-of-range stores would wrap onto low words
    a_no_write_out_of_range: assert property (
        @(posedge clk) disable iff (rst)
        !wr.in_range |-> wr.lane_we == 4'b0000
    ) else $error("bank write with out-of-range address");

endmodule

/* hdl/load_align.sv */
`timescale 1ns/1ps

module load_align
    import rv32_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    mem_write_if.result rd,
    input  rv32_word    data_rdata,
    output logic        load_valid,
    output rv32_word    load_data,
    output logic        misaligned
);
    mem_op_t    op_q;
    logic [1:0] off_q;
    logic       mis_q;
    lane_word_u lanes;

    // Follows the bank read by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            op_q  <= MEM_NONE;
            mis_q <= 1'b0;
        end else begin
            op_q  <= rd.op;
            mis_q <= rd.misaligned;
        end
    end

    always_ff @(posedge clk) begin
        off_q <= rd.byte_off;
    end

    assign lanes = data_rdata;

    always_comb begin
        case (op_q)
            MEM_LB:  load_data = {{24{lanes.bytes[off_q][7]}}, lanes.bytes[off_q]};
            MEM_LBU: load_data = {24'b0, lanes.bytes[off_q]};
            MEM_LH:  load_data = {{16{lanes.halves[off_q[1]][15]}}, lanes.halves[off_q[1]]};
            MEM_LHU: load_data = {16'b0, lanes.halves[off_q[1]]};
            MEM_LW:  load_data = lanes;
            default: load_data = '0;
        endcase
        if (mis_q) begin
            load_data = '0; // Refused access
        end
    end

    assign load_valid = is_load(op_q);
    assign misaligned = mis_q; // Stores flag too

    a_idle_no_result: assert property (
        @(posedge clk) disable iff (rst)
        rd.op == MEM_NONE |=> !load_valid && !misaligned
    ) else $error("result pulse after an idle request");

endmodule

/* hdl/rv32_mem_top.sv */
`timescale 1ns/1ps

module rv32_mem_top
    import rv32_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // Instruction port
    input  rv32_addr instr_addr,
    input  logic     instr_read,
    output logic     instr_ready,
    output rv32_word instr,
    // Data port
    input  mem_op_t  data_op,
    input  rv32_addr data_addr,
    input  rv32_word data_wdata,
    output logic     data_ready,
    output logic     load_valid,
    output rv32_word load_data,
    output logic     misaligned
);
    rv32_word data_rdata;

    mem_write_if wr_if (.clk(clk));

    mem_request_decode u_decode (
        .data_op    (data_op),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .wr         (wr_if.decoder)
    );

    rv32_main_memory u_memory (
        .clk         (clk),
        .rst         (rst),
        .instr_addr  (instr_addr),
        .instr_read  (instr_read),
        .instr_ready (instr_ready),
        .instr       (instr),
        .wr          (wr_if.memory),
        .data_ready  (data_ready),
        .data_rdata  (data_rdata)
    );

    load_align u_result (
        .clk        (clk),
        .rst        (rst),
        .rd         (wr_if.result),
        .data_rdata (data_rdata),
        .load_valid (load_valid),
        .load_data  (load_data),
        .misaligned (misaligned)
    );

endmodule

/* testbench/tb_rv32_mem_top.sv */
`timescale 1ns/1ps

module tb_rv32_mem_top
    import rv32_mem_pkg::*;
();
    localparam int unsigned WINDOW_WORDS = 64;   // Test window starts at word 0
    localparam int unsigned MAX_CYCLES   = 5000;

    logic     clk;
    logic     rst;
    rv32_addr instr_addr;
    logic     instr_read;
    logic     instr_ready;
    rv32_word instr;
    mem_op_t  data_op;
    rv32_addr data_addr;
    rv32_word data_wdata;
    logic     data_ready;
    logic     load_valid;
    rv32_word load_data;
    logic     misaligned;

    int       seed;
    int       errors;
    int       checks;
    string    test_name;

    // Reference model and pending results
    logic [7:0] model_mem [MEM_WORDS*4];
    rv32_word   load_q [$];                   // Holds at most one entry
    rv32_word   exp_instr;
    logic       exp_valid;
    logic       exp_mis;

    mem_op_t mixed_ops [8] = '{MEM_SB, MEM_SH, MEM_SW, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    mem_op_t split_ops [5] = '{MEM_SH, MEM_SW, MEM_LH, MEM_LHU, MEM_LW};

    rv32_mem_top UUT (
        .clk         (clk),
        .rst         (rst),
        .instr_addr  (instr_addr),
        .instr_read  (instr_read),
        .instr_ready (instr_ready),
        .instr       (instr),
        .data_op     (data_op),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_ready  (data_ready),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .misaligned  (misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned random_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic rv32_word random_word();
        return rv32_word'($random(seed));
    endfunction

    function automatic logic reads_memory(mem_op_t op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    endfunction

    function automatic logic in_memory(rv32_addr addr);
        return addr[31:2] < MEM_WORDS;
    endfunction

    // Halfwords need an even address, words a multiple of four
    function automatic logic split_access(mem_op_t op, rv32_addr addr);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: return addr[0];
            MEM_LW, MEM_SW:          return addr[1:0] != 2'b00;
            default:                 return 1'b0;
        endcase
    endfunction

    function automatic rv32_word model_word(int unsigned word);
        int unsigned a;
        a = word * 4;
        return {model_mem[a+3], model_mem[a+2], model_mem[a+1], model_mem[a]};
    endfunction

    function automatic rv32_word expect_load(mem_op_t op, rv32_addr addr);
        int unsigned a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr;
        if (split_access(op, addr)) begin
            return '0;                        // Refused load reads as zero
        end
        b = model_mem[a];
        h = {model_mem[a+1], model_mem[a]};
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'b0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'b0, h};
            default: return model_word(a / 4);
        endcase
    endfunction

    task automatic apply_store(mem_op_t op, rv32_addr addr, rv32_word wdata);
        int unsigned a;
        a = addr;
        if (in_memory(addr) && !split_access(op, addr)) begin
            case (op)
                MEM_SB: model_mem[a] = wdata[7:0];
                MEM_SH: begin
                    model_mem[a]   = wdata[7:0];
                    model_mem[a+1] = wdata[15:8];
                end
                MEM_SW: begin
                    for (int i = 0; i < 4; i++) begin
                        model_mem[a+i] = wdata[8*i +: 8];
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic compare_word(string what, rv32_word expected, rv32_word actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic compare_flag(string what, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch in %s, %s: expected %b, actual %b",
                     test_name, what, expected, actual);
        end
    endtask

    // Results of the request from the cycle before
    task automatic check_outputs();
        rv32_word expected;
        compare_flag("load_valid", exp_valid, load_valid);
        compare_flag("misaligned", exp_mis, misaligned);
        if (load_q.size() > 0) begin
            expected = load_q.pop_front();
            compare_word("load_data", expected, load_data);
        end
        compare_word("instr", exp_instr, instr);
    endtask

    // One request cycle on both ports
    task automatic run_cycle(mem_op_t op, rv32_addr addr, rv32_word wdata,
                             logic fetch, rv32_addr faddr);
        @(posedge clk);
        data_op    <= op;
        data_addr  <= addr;
        data_wdata <= wdata;
        instr_read <= fetch;
        instr_addr <= faddr;
        @(negedge clk);
        check_outputs();
        compare_flag("data_ready", in_memory(addr), data_ready);
        compare_flag("instr_ready", in_memory(faddr), instr_ready);
        // Expectations read the model before the store lands
        if (fetch) begin
            exp_instr = model_word(faddr[31:2]);
        end
        exp_valid = reads_memory(op);
        exp_mis   = split_access(op, addr);
        if (reads_memory(op) && (in_memory(addr) || exp_mis)) begin
            load_q.push_back(expect_load(op, addr));
        end
        apply_store(op, addr, wdata);
    endtask

    function automatic rv32_addr window_addr(mem_op_t op);
        int unsigned word;
        int unsigned off;
        word = random_below(WINDOW_WORDS);
        case (op)
            MEM_SB, MEM_LB, MEM_LBU: off = random_below(4);
            MEM_SH, MEM_LH, MEM_LHU: off = 2 * random_below(2);
            default:                 off = 0;
        endcase
        return rv32_addr'(word * 4 + off);
    endfunction

    initial begin
        mem_op_t     op;
        rv32_addr    addr;
        rv32_addr    faddr;
        int unsigned w;
        logic        fetch;
        seed       = 85794;
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        instr_addr = '0;
        instr_read = 1'b0;
        data_op    = MEM_NONE;
        data_addr  = '0;
        data_wdata = '0;
        exp_instr  = '0;
        exp_valid  = 1'b0;
        exp_mis    = 1'b0;

        test_name = "reset";
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs();

        test_name = "fill_and_fetch";
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            run_cycle(MEM_SW, rv32_addr'(i * 4), random_word(), 1'b0, '0);
        end
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            faddr = rv32_addr'(random_below(WINDOW_WORDS) * 4);
            run_cycle(MEM_NONE, '0, '0, 1'b1, faddr);
        end

        test_name = "random_mixed";
        for (int i = 0; i < 400; i++) begin
            op    = mixed_ops[random_below(8)];
            addr  = window_addr(op);
            fetch = random_below(2) == 1;
            faddr = rv32_addr'(random_below(WINDOW_WORDS) * 4);
            run_cycle(op, addr, random_word(), fetch, faddr);
        end

        test_name = "misaligned";
        for (int i = 0; i < 60; i++) begin
            op = split_ops[random_below(5)];
            w  = random_below(WINDOW_WORDS);
            if (op inside {MEM_SW, MEM_LW}) begin
                addr = rv32_addr'(w * 4 + 1 + random_below(3));
            end else begin
                addr = rv32_addr'(w * 4 + 1 + 2 * random_below(2)); // Odd offset
            end
            run_cycle(op, addr, random_word(), 1'b0, '0);
            run_cycle(MEM_LW, rv32_addr'(w * 4), '0, 1'b0, '0); // Word must be unchanged
        end

        test_name = "range";
        for (int i = 0; i < 32; i++) begin
            w    = random_below(WINDOW_WORDS);
            addr = rv32_addr'((MEM_WORDS + w) * 4); // Would alias window word w
            run_cycle(MEM_SW, addr, random_word(), 1'b0, addr);
            run_cycle(MEM_LW, addr, '0, 1'b0, '0);
        end
        addr = rv32_addr'(MEM_WORDS * 4); // First word past the end
        run_cycle(MEM_SW, addr, random_word(), 1'b0, addr);
        run_cycle(MEM_SB, 32'hffff_fffc, random_word(), 1'b0, 32'hffff_fff0);
        addr = rv32_addr'((MEM_WORDS - 1) * 4); // Last word still in range
        run_cycle(MEM_NONE, addr, '0, 1'b0, addr);
        test_name = "range_window_sweep";
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            run_cycle(MEM_LW, rv32_addr'(i * 4), '0, 1'b1, rv32_addr'(i * 4));
        end

        test_name = "read_first";
        for (int i = 0; i < 16; i++) begin
            addr = rv32_addr'(random_below(WINDOW_WORDS) * 4);
            run_cycle(MEM_SW, addr, random_word(), 1'b1, addr); // Fetch sees old word
            run_cycle(MEM_LW, addr, '0, 1'b1, addr);
        end

        // Drain the last result
        run_cycle(MEM_NONE, '0, '0, 1'b0, '0);
        run_cycle(MEM_NONE, '0, '0, 1'b0, '0);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clk);
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* files.f */
hdl/rv32_mem_pkg.sv
hdl/mem_write_if.sv
hdl/bram_bank.sv
hdl/mem_request_decode.sv
hdl/rv32_main_memory.sv
hdl/load_align.sv
hdl/rv32_mem_top.sv
testbench/tb_rv32_mem_top.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_rv32_mem_top
RTL_TOP    = rv32_mem_top
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log

SHELL := /bin/bash

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
